// File: rob_top.f
+incdir+include
src/rob_pkg.sv
src/rob_ptr_ctr.sv
src/rob_entry.sv
src/rob_commit_sel.sv
src/rob_top.sv
testbench/rob_props.sv
testbench/rob_tb.sv

// File: build.sh
#!/usr/bin/env bash
# compile the reorder buffer testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module rob_tb \
  -f rob_top.f --Mdir obj_dir -o rob_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: include/rob_tb_tasks.svh
//--------------------------------------------------------------------
// dispatch and done-report drivers plus the directed tests,
// included into the body of the testbench top
//--------------------------------------------------------------------
`ifndef ROB_TB_TASKS_SVH
`define ROB_TB_TASKS_SVH

// all drivers start and end 1 ns after a rising edge
task automatic dispatch_group(input grp_id_t grp, input vaddr_t pc, input grp_id_t ill,
                              output cmt_id_t id);
  check("new_cmt_id", 64'(next_id), 64'(o_new_cmt_id));
  id             = next_id;
  next_id        = next_id + cmt_id_t'(1);
  i_disp_valid   = 1'b1;
  i_disp_grp_id  = grp;
  i_disp_pc      = pc;
  i_disp_illegal = ill;
  @(posedge i_clk);
  #1;
  i_disp_valid = 1'b0;
endtask

task automatic report_done(input cmt_id_t id, input grp_id_t lane, input logic exv,
                           input except_t ext);
  i_done_valid        = 1'b1;
  i_done_cmt_id       = id;
  i_done_lane         = lane;
  i_done_except_valid = exv;
  i_done_except_type  = ext;
  @(posedge i_clk);
  #1;
  i_done_valid = 1'b0;
endtask

task automatic test_reset();
  start_test("reset");
  check("commit_valid", 64'(0), 64'(o_commit_valid));
  check("cre_ret_valid", 64'(0), 64'(o_cre_ret_valid));
  check("new_cmt_id", 64'(0), 64'(o_new_cmt_id));
  finish_test();
endtask

task automatic test_in_order();
  cmt_id_t id_a;
  cmt_id_t id_b;
  cmt_id_t id_c;
  int      cmt0;
  int      cre0;
  start_test("in_order");
  cmt0 = cmt_count;
  cre0 = cre_count;
  dispatch_group(2'b01, 32'h0000_1000, 2'b00, id_a);
  push_expect(id_a, 2'b01, 32'h0000_1000, 2'b00, 4'd0, 4'd0, 1'b0);
  dispatch_group(2'b11, 32'h0000_1004, 2'b00, id_b);
  push_expect(id_b, 2'b11, 32'h0000_1004, 2'b00, 4'd0, 4'd0, 1'b0);
  dispatch_group(2'b10, 32'h0000_100c, 2'b00, id_c);
  push_expect(id_c, 2'b10, 32'h0000_100c, 2'b00, 4'd0, 4'd0, 1'b0);
  // youngest first
  report_done(id_c, 2'b10, 1'b0, 4'd0);
  report_done(id_b, 2'b10, 1'b0, 4'd0);
  report_done(id_b, 2'b01, 1'b0, 4'd0);
  report_done(id_a, 2'b01, 1'b0, 4'd0);
  wait_drain(50);
  check("commits", 64'(3), 64'(cmt_count - cmt0));
  check("credit pulses", 64'(3), 64'(cre_count - cre0));
  finish_test();
endtask

task automatic test_done_except();
  cmt_id_t id_a;
  cmt_id_t id_b;
  cmt_id_t id_c;
  start_test("done_except");
  dispatch_group(2'b11, 32'h0000_3000, 2'b00, id_a);
  push_expect(id_a, 2'b11, 32'h0000_3000, 2'b01, 4'd5, 4'd0, 1'b0);
  dispatch_group(2'b01, 32'h0000_3008, 2'b00, id_b);
  push_expect(id_b, 2'b01, 32'h0000_3008, 2'b00, 4'd0, 4'd0, 1'b1);
  dispatch_group(2'b11, 32'h0000_300c, 2'b00, id_c);
  push_expect(id_c, 2'b11, 32'h0000_300c, 2'b00, 4'd0, 4'd0, 1'b1);
  report_done(id_a, 2'b01, 1'b1, 4'd5);
  report_done(id_a, 2'b10, 1'b0, 4'd0);   // b and c get no reports
  wait_drain(50);
  finish_test();
endtask

task automatic test_illegal();
  cmt_id_t id_a;
  int      cmt0;
  start_test("illegal");
  cmt0 = cmt_count;
  dispatch_group(2'b11, 32'h0000_4000, 2'b10, id_a);
  push_expect(id_a, 2'b11, 32'h0000_4000, 2'b10, 4'd0, ILLEGAL_INST, 1'b0);
  repeat (3) begin
    @(posedge i_clk);
    #1;
  end
  check("early commits", 64'(0), 64'(cmt_count - cmt0));
  report_done(id_a, 2'b01, 1'b0, 4'd0);
  wait_drain(50);
  finish_test();
endtask

task automatic test_wrap();
  int      remaining;
  int      batch;
  int      npend;
  int      j;
  cmt_id_t id;
  grp_id_t grp;
  vaddr_t  pc;
  cmt_id_t pend_id   [16];
  grp_id_t pend_lane [16];
  cmt_id_t tmp_id;
  grp_id_t tmp_lane;
  start_test("wrap");
  remaining = 20;
  pc        = 32'h0000_8000;
  while (remaining > 0) begin
    batch = 1 + int'($unsigned($random(seed)) % 8);   // never more than 8 in flight
    if (batch > remaining) begin
      batch = remaining;
    end
    npend = 0;
    for (int g = 0; g < batch; g++) begin
      grp = grp_id_t'(1 + $unsigned($random(seed)) % 3);
      dispatch_group(grp, pc, 2'b00, id);
      push_expect(id, grp, pc, 2'b00, 4'd0, 4'd0, 1'b0);
      for (int l = 0; l < DISP_SIZE; l++) begin
        if (grp[l]) begin
          pend_id[npend]   = id;
          pend_lane[npend] = grp_id_t'(1 << l);
          npend++;
        end
      end
      pc = pc + vaddr_t'(8);
    end
    // shuffle the done reports
    for (int k = npend - 1; k > 0; k--) begin
      j            = int'($unsigned($random(seed)) % (k + 1));
      tmp_id       = pend_id[k];
      tmp_lane     = pend_lane[k];
      pend_id[k]   = pend_id[j];
      pend_lane[k] = pend_lane[j];
      pend_id[j]   = tmp_id;
      pend_lane[j] = tmp_lane;
    end
    for (int k = 0; k < npend; k++) begin
      report_done(pend_id[k], pend_lane[k], 1'b0, 4'd0);
    end
    wait_drain(50);
    remaining = remaining - batch;
  end
  finish_test();
endtask

`endif

// File: testbench/rob_tb.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------
// testbench for the reorder buffer: clock, reset, scoreboard and a
// commit monitor; directed tests come from the included task file
//--------------------------------------------------------------------

module rob_tb;

  import rob_pkg::*;

  typedef struct packed {
    cmt_id_t id;
    grp_id_t grp;
    grp_id_t exv;
    except_t ext;
    vaddr_t  epc;
    grp_id_t dead_id;
    logic    flush;
  } commit_t;

  logic    i_clk;
  logic    i_reset_n;
  logic    i_disp_valid;
  grp_id_t i_disp_grp_id;
  vaddr_t  i_disp_pc;
  grp_id_t i_disp_illegal;
  cmt_id_t o_new_cmt_id;
  logic    i_done_valid;
  cmt_id_t i_done_cmt_id;
  grp_id_t i_done_lane;
  logic    i_done_except_valid;
  except_t i_done_except_type;
  logic    o_commit_valid;
  cmt_id_t o_commit_cmt_id;
  grp_id_t o_commit_grp_id;
  grp_id_t o_commit_except_valid;
  except_t o_commit_except_type;
  vaddr_t  o_commit_epc;
  grp_id_t o_commit_dead_id;
  logic    o_commit_flush;
  logic    o_cre_ret_valid;
  credit_t o_cre_ret_val;

  commit_t exp_q [$];    // expected commits, oldest first
  cmt_id_t next_id;      // id the next dispatch should receive
  string   test_name;
  int      err_count;
  int      err_at_start;
  int      test_count;
  int      cmt_count;
  int      cre_count;
  integer  seed;

  rob_top i_rob_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp_v, act_v);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_count;
    test_count++;
  endtask

  task automatic finish_test();
    $display("test %s done, %0d errors", test_name, err_count - err_at_start);
  endtask

  //--------------------------------------------------------------------
  // scoreboard
  //--------------------------------------------------------------------
  // expected commit from the group, its exception lanes and its codes
  task automatic push_expect(input cmt_id_t id, input grp_id_t grp, input vaddr_t pc,
                             input grp_id_t ex, input except_t t0, input except_t t1,
                             input logic dead);
    commit_t c;
    int      lane;
    c     = '0;
    c.id  = id;
    c.grp = grp;
    c.epc = pc;
    if (dead) begin
      c.dead_id = grp;
    end else begin
      lane = 0;
      while (lane < DISP_SIZE && !(ex[lane] & grp[lane])) begin
        lane++;
      end
      if (lane < DISP_SIZE) begin
        c.exv[lane] = 1'b1;
        c.ext       = (lane == 0) ? t0 : t1;
        c.epc       = pc + vaddr_t'(lane * INST_BYTES);
        c.flush     = 1'b1;
        for (int k = lane + 1; k < DISP_SIZE; k++) begin
          c.dead_id[k] = grp[k];
        end
      end
    end
    exp_q.push_back(c);
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout in test %s: %0d commits never arrived", test_name, exp_q.size());
      err_count++;
      exp_q.delete();
    end
    repeat (2) begin   // last credit pulse
      @(posedge i_clk);
      #1;
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge i_clk) begin : commit_monitor
    commit_t exp_c;
    if (i_reset_n) begin
      if (o_cre_ret_valid) begin
        cre_count++;
        check("cre_ret_val", 64'(1), 64'(o_cre_ret_val));
      end
      if (o_commit_valid) begin
        cmt_count++;
        if (exp_q.size() == 0) begin
          $display("unexpected commit of id %0d in test %s", o_commit_cmt_id, test_name);
          err_count++;
        end else begin
          exp_c = exp_q.pop_front();
          check("cmt_id", 64'(exp_c.id), 64'(o_commit_cmt_id));
          check("grp_id", 64'(exp_c.grp), 64'(o_commit_grp_id));
          check("except_valid", 64'(exp_c.exv), 64'(o_commit_except_valid));
          check("dead_id", 64'(exp_c.dead_id), 64'(o_commit_dead_id));
          check("flush", 64'(exp_c.flush), 64'(o_commit_flush));
          if (exp_c.exv != '0) begin
            check("except_type", 64'(exp_c.ext), 64'(o_commit_except_type));
            check("epc", 64'(exp_c.epc), 64'(o_commit_epc));
          end
        end
      end
    end
  end

  `include "rob_tb_tasks.svh"

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------
  initial begin
    seed                = 34664;
    err_count           = 0;
    err_at_start        = 0;
    test_count          = 0;
    cmt_count           = 0;
    cre_count           = 0;
    test_name           = "init";
    next_id             = '0;
    i_reset_n           = 1'b0;
    i_disp_valid        = 1'b0;
    i_disp_grp_id       = '0;
    i_disp_pc           = '0;
    i_disp_illegal      = '0;
    i_done_valid        = 1'b0;
    i_done_cmt_id       = '0;
    i_done_lane         = '0;
    i_done_except_valid = 1'b0;
    i_done_except_type  = '0;
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    test_reset();
    test_in_order();
    test_done_except();
    test_illegal();
    test_wrap();

    $display("tests %0d, commits %0d, credit pulses %0d, errors %0d",
             test_count, cmt_count, cre_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/rob_props.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------
// concurrent assertions on the commit and credit ports, bound to rob_top
//--------------------------------------------------------------------

module rob_props (
  input logic             i_clk,
  input logic             i_reset_n,
  input logic             i_commit_valid,
  input logic             i_head_valid,
  input rob_pkg::grp_id_t i_except_valid,
  input rob_pkg::credit_t i_cre_ret_val
);

  a_commit_head: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> i_head_valid)
    else $error("commit while the head entry is empty");

  a_except_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_except_valid))
    else $error("more than one excepting lane at commit");

  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_cre_ret_val <= 1)
    else $error("credit return above one");

  // no retire while the core is held in reset
  a_reset_quiet: assert property (@(posedge i_clk) !i_reset_n |-> !i_commit_valid)
    else $error("commit during reset");

endmodule

bind rob_top rob_props u_props (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_commit_valid (o_commit_valid),
  .i_head_valid   (w_valid[w_head]),
  .i_except_valid (o_commit_except_valid),
  .i_cre_ret_val  (o_cre_ret_val)
);

// File: src/rob_top.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------
// reorder buffer for a two-wide dispatch core; groups enter by
// dispatch strobe, retire in order, and return one credit each
//--------------------------------------------------------------------

module rob_top (
  input  logic             i_clk,
  input  logic             i_reset_n,
  // dispatch
  input  logic             i_disp_valid,
  input  rob_pkg::grp_id_t i_disp_grp_id,
  input  rob_pkg::vaddr_t  i_disp_pc,
  input  rob_pkg::grp_id_t i_disp_illegal,
  output rob_pkg::cmt_id_t o_new_cmt_id,
  // done report
  input  logic             i_done_valid,
  input  rob_pkg::cmt_id_t i_done_cmt_id,
  input  rob_pkg::grp_id_t i_done_lane,
  input  logic             i_done_except_valid,
  input  rob_pkg::except_t i_done_except_type,
  // commit
  output logic             o_commit_valid,
  output rob_pkg::cmt_id_t o_commit_cmt_id,
  output rob_pkg::grp_id_t o_commit_grp_id,
  output rob_pkg::grp_id_t o_commit_except_valid,
  output rob_pkg::except_t o_commit_except_type,
  output rob_pkg::vaddr_t  o_commit_epc,
  output rob_pkg::grp_id_t o_commit_dead_id,
  output logic             o_commit_flush,
  // credit return
  output logic             o_cre_ret_valid,
  output rob_pkg::credit_t o_cre_ret_val
);

  import rob_pkg::*;

  cmt_id_t       w_in_cmt_id;
  cmt_id_t       w_out_cmt_id;
  cmt_entry_id_t w_in_entry;
  cmt_entry_id_t w_head;
  logic          w_commit_valid;
  logic          w_flush;

  logic [CMT_ENTRY_SIZE-1:0] w_load;
  logic [CMT_ENTRY_SIZE-1:0] w_kill;
  logic [CMT_ENTRY_SIZE-1:0] w_commit;
  logic [CMT_ENTRY_SIZE-1:0] w_valid;
  logic [CMT_ENTRY_SIZE-1:0] w_all_done;
  logic [CMT_ENTRY_SIZE-1:0] w_dead;

  grp_id_t w_grp_id       [CMT_ENTRY_SIZE];
  grp_id_t w_except_valid [CMT_ENTRY_SIZE];
  vaddr_t  w_pc           [CMT_ENTRY_SIZE];
  except_t w_except_type  [CMT_ENTRY_SIZE][DISP_SIZE];
  except_t w_head_except_type [DISP_SIZE];

  //--------------------------------------------------------------------
  // pointers and credits
  //--------------------------------------------------------------------
  rob_ptr_ctr u_ptr_ctr (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_commit_valid  (w_commit_valid),
    .o_in_cmt_id     (w_in_cmt_id),
    .o_out_cmt_id    (w_out_cmt_id),
    .o_cre_ret_valid (o_cre_ret_valid),
    .o_cre_ret_val   (o_cre_ret_val)
  );

  assign w_in_entry = w_in_cmt_id[CMT_ENTRY_W-1:0];
  assign w_head     = w_out_cmt_id[CMT_ENTRY_W-1:0];

  //--------------------------------------------------------------------
  // entry array
  //--------------------------------------------------------------------
  for (genvar c = 0; c < CMT_ENTRY_SIZE; c++) begin : g_entry
    assign w_load[c]   = i_disp_valid & (w_in_entry == cmt_entry_id_t'(c));
    assign w_commit[c] = w_commit_valid & (w_head == cmt_entry_id_t'(c));
    assign w_kill[c]   = w_flush & (w_head != cmt_entry_id_t'(c));  // all but the flusher

    rob_entry u_entry (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_entry_id          (cmt_entry_id_t'(c)),
      .i_load              (w_load[c]),
      .i_load_grp_id       (i_disp_grp_id),
      .i_load_illegal      (i_disp_illegal),
      .i_load_pc           (i_disp_pc),
      .i_load_dead         (w_flush),       // a group dispatched during a flush is dead
      .i_done_valid        (i_done_valid),
      .i_done_cmt_id       (i_done_cmt_id),
      .i_done_lane         (i_done_lane),
      .i_done_except_valid (i_done_except_valid),
      .i_done_except_type  (i_done_except_type),
      .i_kill              (w_kill[c]),
      .i_commit            (w_commit[c]),
      .o_valid             (w_valid[c]),
      .o_all_done          (w_all_done[c]),
      .o_dead              (w_dead[c]),
      .o_grp_id            (w_grp_id[c]),
      .o_except_valid      (w_except_valid[c]),
      .o_pc                (w_pc[c]),
      .o_except_type       (w_except_type[c])
    );
  end

  // head codes, lane by lane
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_head_type
    assign w_head_except_type[d] = w_except_type[w_head][d];
  end

  //--------------------------------------------------------------------
  // commit of the head group
  //--------------------------------------------------------------------
  rob_commit_sel u_commit_sel (
    .i_head_valid        (w_valid[w_head]),
    .i_head_all_done     (w_all_done[w_head]),
    .i_head_dead         (w_dead[w_head]),
    .i_head_grp_id       (w_grp_id[w_head]),
    .i_head_except_valid (w_except_valid[w_head]),
    .i_head_pc           (w_pc[w_head]),
    .i_head_except_type  (w_head_except_type),
    .o_commit_valid      (w_commit_valid),
    .o_except_valid      (o_commit_except_valid),
    .o_dead_id           (o_commit_dead_id),
    .o_except_type       (o_commit_except_type),
    .o_epc               (o_commit_epc),
    .o_flush             (w_flush)
  );

  assign o_new_cmt_id    = w_in_cmt_id;
  assign o_commit_valid  = w_commit_valid;
  assign o_commit_cmt_id = w_out_cmt_id;
  assign o_commit_grp_id = w_grp_id[w_head];
  assign o_commit_flush  = w_flush;

endmodule

// File: src/rob_commit_sel.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------
// commit decision for the head group: exception lane, epc, dead lanes
//--------------------------------------------------------------------

module rob_commit_sel (
  input  logic             i_head_valid,
  input  logic             i_head_all_done,
  input  logic             i_head_dead,
  input  rob_pkg::grp_id_t i_head_grp_id,
  input  rob_pkg::grp_id_t i_head_except_valid,
  input  rob_pkg::vaddr_t  i_head_pc,
  input  rob_pkg::except_t i_head_except_type [rob_pkg::DISP_SIZE],
  output logic             o_commit_valid,
  output rob_pkg::grp_id_t o_except_valid,
  output rob_pkg::grp_id_t o_dead_id,
  output rob_pkg::except_t o_except_type,
  output rob_pkg::vaddr_t  o_epc,
  output logic             o_flush
);

  import rob_pkg::*;

  grp_id_t w_live_except;   // exceptions that still count
  grp_id_t w_except_oh;     // lowest excepting lane
  grp_id_t w_above;         // lanes younger than that lane
  except_t w_type_sel;
  vaddr_t  w_lane_off;

  assign o_commit_valid = i_head_valid & i_head_all_done;

  // a squashed group reports nothing
  assign w_live_except = i_head_dead ? '0 : (i_head_except_valid & i_head_grp_id);

  //--------------------------------------------------------------------
  // lane selection
  //--------------------------------------------------------------------
  always_comb begin
    logic seen;
    seen        = 1'b0;
    w_except_oh = '0;
    w_above     = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_above[d]     = seen;
      w_except_oh[d] = w_live_except[d] & ~seen;
      seen           = seen | w_live_except[d];
    end
  end

  // one-hot select of code and lane offset
  always_comb begin
    w_type_sel = '0;
    w_lane_off = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_except_oh[d]) begin
        w_type_sel = w_type_sel | i_head_except_type[d];
        w_lane_off = vaddr_t'(d * INST_BYTES);
      end
    end
  end

  //--------------------------------------------------------------------
  // commit outputs
  //--------------------------------------------------------------------
  assign o_except_valid = w_except_oh;
  assign o_except_type  = w_type_sel;
  assign o_epc          = i_head_pc + w_lane_off;

  // the excepting lane itself stays live, only younger ones die
  assign o_dead_id = (w_above | {DISP_SIZE{i_head_dead}}) & i_head_grp_id;

  assign o_flush = o_commit_valid & (|w_except_oh);

endmodule

// File: src/rob_entry.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------
// one reorder buffer slot holding a dispatch group; rob_top keeps one
// copy per slot and drives its load, kill and commit strobes
//--------------------------------------------------------------------

module rob_entry (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  rob_pkg::cmt_entry_id_t i_entry_id,
  input  logic                   i_load,
  input  rob_pkg::grp_id_t       i_load_grp_id,
  input  rob_pkg::grp_id_t       i_load_illegal,
  input  rob_pkg::vaddr_t        i_load_pc,
  input  logic                   i_load_dead,
  input  logic                   i_done_valid,
  input  rob_pkg::cmt_id_t       i_done_cmt_id,
  input  rob_pkg::grp_id_t       i_done_lane,
  input  logic                   i_done_except_valid,
  input  rob_pkg::except_t       i_done_except_type,
  input  logic                   i_kill,
  input  logic                   i_commit,
  output logic                   o_valid,
  output logic                   o_all_done,
  output logic                   o_dead,
  output rob_pkg::grp_id_t       o_grp_id,
  output rob_pkg::grp_id_t       o_except_valid,
  output rob_pkg::vaddr_t        o_pc,
  output rob_pkg::except_t       o_except_type [rob_pkg::DISP_SIZE]
);

  import rob_pkg::*;

  logic    r_valid;
  logic    r_dead;          // whole group squashed by an older flush
  grp_id_t r_done;
  grp_id_t r_except_valid;
  grp_id_t r_grp_id;
  vaddr_t  r_pc;
  except_t r_except_type [DISP_SIZE];

  logic    w_done_hit;
  grp_id_t w_load_done;
  grp_id_t w_load_except;
  grp_id_t w_done_except;

  // done reports carry the full id, the wrap bit is not compared
  assign w_done_hit = i_done_valid & r_valid &
                      (i_done_cmt_id[CMT_ENTRY_W-1:0] == i_entry_id);

  // illegal lanes never execute, so they are done at dispatch
  assign w_load_except = i_load_dead ? '0 : (i_load_illegal & i_load_grp_id);
  assign w_load_done   = i_load_dead ? i_load_grp_id : w_load_except;

  assign w_done_except = (w_done_hit & i_done_except_valid & ~r_dead) ?
                         (i_done_lane & r_grp_id) : '0;

  //--------------------------------------------------------------------
  // control state
  //--------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_dead         <= 1'b0;
      r_done         <= '0;
      r_except_valid <= '0;
    end else if (i_load) begin
      r_valid        <= 1'b1;
      r_dead         <= i_load_dead;
      r_done         <= w_load_done;
      r_except_valid <= w_load_except;
    end else if (i_commit) begin
      r_valid <= 1'b0;
    end else if (i_kill & r_valid) begin
      r_dead <= 1'b1;
      r_done <= r_grp_id;   // dead groups drain without done reports
    end else if (w_done_hit) begin
      r_done         <= r_done | (i_done_lane & r_grp_id);
      r_except_valid <= r_except_valid | w_done_except;
    end
  end

  //--------------------------------------------------------------------
  // group payload
  //--------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_grp_id <= i_load_grp_id;
      r_pc     <= i_load_pc;    // pc of lane 0
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (i_load & w_load_except[d]) begin
        r_except_type[d] <= ILLEGAL_INST;
      end else if (w_done_except[d]) begin
        r_except_type[d] <= i_done_except_type;
      end
    end
  end

  assign o_valid        = r_valid;
  assign o_all_done     = r_valid & (r_done == r_grp_id);
  assign o_dead         = r_dead;
  assign o_grp_id       = r_grp_id;
  assign o_except_valid = r_except_valid;
  assign o_pc           = r_pc;
  assign o_except_type  = r_except_type;

endmodule

// File: src/rob_ptr_ctr.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------
// allocation and commit pointers of the reorder buffer, plus the
// registered credit return toward the dispatch stage
//--------------------------------------------------------------------

module rob_ptr_ctr (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  logic             i_commit_valid,
  output rob_pkg::cmt_id_t o_in_cmt_id,
  output rob_pkg::cmt_id_t o_out_cmt_id,
  output logic             o_cre_ret_valid,
  output rob_pkg::credit_t o_cre_ret_val
);

  import rob_pkg::*;

  cmt_id_t r_in_ptr;     // next slot to allocate
  cmt_id_t r_out_ptr;    // head of the buffer
  logic    r_cre_valid;
  credit_t r_cre_val;
  credit_t w_cmt_count;

  // at most one group retires per cycle
  assign w_cmt_count = credit_t'(i_commit_valid);

  //--------------------------------------------------------------------
  // pointers
  //--------------------------------------------------------------------
  // the wrap bit toggles each time an index passes the last entry
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_disp_valid) begin
        r_in_ptr <= r_in_ptr + cmt_id_t'(1);
      end
      if (i_commit_valid) begin
        r_out_ptr <= r_out_ptr + cmt_id_t'(1);
      end
    end
  end

  //--------------------------------------------------------------------
  // credit return
  //--------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cre_valid <= 1'b0;
      r_cre_val   <= '0;
    end else begin
      r_cre_valid <= i_commit_valid;
      r_cre_val   <= w_cmt_count;   // zero in idle cycles
    end
  end

  assign o_in_cmt_id     = r_in_ptr;
  assign o_out_cmt_id    = r_out_ptr;
  assign o_cre_ret_valid = r_cre_valid;
  assign o_cre_ret_val   = r_cre_val;

endmodule

// File: src/rob_pkg.sv
//--------------------------------------------------------------------
// sizes, vector types and exception codes of the reorder buffer
// imported by the design modules and by the testbench
//--------------------------------------------------------------------

package rob_pkg;

  //--------------------------------------------------------------------
  // geometry
  //--------------------------------------------------------------------
  localparam int DISP_SIZE      = 2;    // lanes per dispatch group
  localparam int CMT_ENTRY_SIZE = 8;    // groups in flight
  localparam int CMT_ENTRY_W    = $clog2(CMT_ENTRY_SIZE);

  localparam int VADDR_W        = 32;
  localparam int INST_BYTES     = 4;    // pc step from one lane to the next

  //--------------------------------------------------------------------
  // vector types
  //--------------------------------------------------------------------
  typedef logic [DISP_SIZE-1:0]   grp_id_t;        // one bit per lane
  typedef logic [CMT_ENTRY_W:0]   cmt_id_t;        // msb is the wrap bit
  typedef logic [CMT_ENTRY_W-1:0] cmt_entry_id_t;
  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [3:0]             except_t;

  // wide enough to return a full buffer of credits at once
  typedef logic [$clog2(CMT_ENTRY_SIZE+1)-1:0] credit_t;

  //--------------------------------------------------------------------
  // exception codes
  //--------------------------------------------------------------------
  localparam except_t ILLEGAL_INST = 4'd2;  // flagged by the decoder at dispatch

endpackage
